//--- logic/axil_ft_pkg.sv
package axil_ft_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;
    typedef logic [1:0]            resp_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response codes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register bank
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // word index taken from address bits 5:2
    localparam int REG_COUNT = 16;

    // consumer FSM, one response outstanding at most
    typedef enum logic [1:0] {
        CONS_IDLE,
        CONS_B_PEND,
        CONS_R_PEND
    } cons_state_e;

endpackage

//--- logic/axil_req_producer.sv
`timescale 1ns/100ps

module axil_req_producer
    import axil_ft_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic  seq,
    input  logic  rst_n,

    input  logic  aw_valid,
    output logic  aw_ready,
    input  addr_t aw_addr,

    input  logic  w_valid,
    output logic  w_ready,
    input  data_t w_data,
    input  strb_t w_strb,

    input  logic  ar_valid,
    output logic  ar_ready,
    input  addr_t ar_addr,

    output logic  push,
    output logic  push_write,
    output addr_t push_addr,
    output data_t push_data,
    output strb_t push_strb,
    input  logic  credit
);

    localparam int CW = $clog2(DEPTH + 1);

    logic [CW-1:0] credit_cnt;
    logic          has_credit;
    logic          write_pair;
    logic          write_go;
    logic          read_go;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // acceptance
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign has_credit = (credit_cnt != '0);

    // AW and W are only taken as a pair
    assign write_pair = aw_valid && w_valid;
    assign write_go   = write_pair && has_credit;

    // writes win, a read waits while a pair is presented
    assign read_go = ar_valid && has_credit && !write_pair;

    assign aw_ready = write_go;
    assign w_ready  = write_go;
    assign ar_ready = read_go;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request towards the buffer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign push       = write_go || read_go;
    assign push_write = write_go;
    assign push_addr  = write_go ? aw_addr : ar_addr;

    // reads carry no payload
    assign push_data = write_go ? w_data : '0;
    assign push_strb = write_go ? w_strb : '0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // credit counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= CW'(DEPTH);
        end else begin
            case ({push, credit})
                2'b10: credit_cnt <= credit_cnt - 1'b1;
                2'b01: credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

endmodule

//--- logic/axil_fall_through_buffer.sv
`timescale 1ns/100ps

module axil_fall_through_buffer
    import axil_ft_pkg::*;
#(
    parameter int DEPTH        = 4,
    parameter int FALL_THROUGH = 1
) (
    input  logic  seq,
    input  logic  rst_n,

    input  logic  push,
    input  logic  push_write,
    input  addr_t push_addr,
    input  data_t push_data,
    input  strb_t push_strb,

    output logic  entry_valid,
    output logic  entry_write,
    output addr_t entry_addr,
    output data_t entry_data,
    output strb_t entry_strb,
    input  logic  pop,

    output logic  credit
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic  mem_write [DEPTH];
    addr_t mem_addr  [DEPTH];
    data_t mem_data  [DEPTH];
    strb_t mem_strb  [DEPTH];

    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;

    logic bypass;
    logic store;
    logic advance;

    // forward the incoming request while nothing is stored
    assign bypass = (FALL_THROUGH != 0) && (count == '0);

    // a request taken straight through never lands in the array
    assign store   = push && !(bypass && pop);
    assign advance = pop && (count != '0);

    assign entry_valid = (count != '0) || (bypass && push);
    assign entry_write = bypass ? push_write : mem_write[rd_ptr];
    assign entry_addr  = bypass ? push_addr  : mem_addr[rd_ptr];
    assign entry_data  = bypass ? push_data  : mem_data[rd_ptr];
    assign entry_strb  = bypass ? push_strb  : mem_strb[rd_ptr];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage and pointers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge seq) begin
        if (store) begin
            mem_write[wr_ptr] <= push_write;
            mem_addr[wr_ptr]  <= push_addr;
            mem_data[wr_ptr]  <= push_data;
            mem_strb[wr_ptr]  <= push_strb;
        end
    end

    // DEPTH need not be a power of two, so wrap explicitly
    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (store) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (advance) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(store) - CW'(advance);
        end
    end

    // one credit back per popped entry, a cycle late
    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            credit <= 1'b0;
        end else begin
            credit <= pop;
        end
    end

endmodule

//--- logic/axil_reg_consumer.sv
`timescale 1ns/100ps

module axil_reg_consumer
    import axil_ft_pkg::*;
(
    input  logic  seq,
    input  logic  rst_n,

    input  logic  entry_valid,
    input  logic  entry_write,
    input  addr_t entry_addr,
    input  data_t entry_data,
    input  strb_t entry_strb,
    output logic  pop,

    output logic  b_valid,
    input  logic  b_ready,
    output resp_t b_resp,

    output logic  r_valid,
    input  logic  r_ready,
    output data_t r_data,
    output resp_t r_resp
);

    localparam int IW = $clog2(REG_COUNT);

    cons_state_e state;
    data_t       regs [REG_COUNT];
    data_t       rdata_q;
    resp_t       resp_q;
    logic        in_range;
    logic [IW-1:0] idx;

    // only bits 5:2 may be set, anything above is an error
    assign in_range = (entry_addr[ADDR_WIDTH-1:6] == '0);
    assign idx      = entry_addr[5:2];

    assign pop = (state == CONS_IDLE) && entry_valid;

    assign b_valid = (state == CONS_B_PEND);
    assign r_valid = (state == CONS_R_PEND);
    assign b_resp  = resp_q;
    assign r_resp  = resp_q;
    assign r_data  = rdata_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            state <= CONS_IDLE;
        end else begin
            case (state)
                CONS_IDLE: begin
                    if (pop) begin
                        state <= entry_write ? CONS_B_PEND : CONS_R_PEND;
                    end
                end
                CONS_B_PEND: begin
                    if (b_ready) begin
                        state <= CONS_IDLE;
                    end
                end
                CONS_R_PEND: begin
                    if (r_ready) begin
                        state <= CONS_IDLE;
                    end
                end
                default: state <= CONS_IDLE;
            endcase
        end
    end

    // response payload, captured with the pop
    always_ff @(posedge seq) begin
        if (pop) begin
            resp_q  <= in_range ? RESP_OKAY : RESP_SLVERR;
            rdata_q <= in_range ? regs[idx] : '0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register bank
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (pop && entry_write && in_range) begin
            // byte merge under strobe
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (entry_strb[b]) begin
                    regs[idx][8*b +: 8] <= entry_data[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- logic/axil_ft_top.sv
`timescale 1ns/100ps

module axil_ft_top
    import axil_ft_pkg::*;
#(
    parameter int DEPTH        = 4,
    parameter int FALL_THROUGH = 1
) (
    input  logic  seq,
    input  logic  rst_n,

    input  logic  aw_valid,
    output logic  aw_ready,
    input  addr_t aw_addr,

    input  logic  w_valid,
    output logic  w_ready,
    input  data_t w_data,
    input  strb_t w_strb,

    output logic  b_valid,
    input  logic  b_ready,
    output resp_t b_resp,

    input  logic  ar_valid,
    output logic  ar_ready,
    input  addr_t ar_addr,

    output logic  r_valid,
    input  logic  r_ready,
    output data_t r_data,
    output resp_t r_resp
);

    // producer to buffer
    logic  push;
    logic  push_write;
    addr_t push_addr;
    data_t push_data;
    strb_t push_strb;
    logic  credit;

    // buffer to consumer
    logic  entry_valid;
    logic  entry_write;
    addr_t entry_addr;
    data_t entry_data;
    strb_t entry_strb;
    logic  pop;

    axil_req_producer #(
        .DEPTH (DEPTH)
    ) axil_req_producer_i (
        .seq        (seq),
        .rst_n      (rst_n),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .aw_addr    (aw_addr),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .w_data     (w_data),
        .w_strb     (w_strb),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .ar_addr    (ar_addr),
        .push       (push),
        .push_write (push_write),
        .push_addr  (push_addr),
        .push_data  (push_data),
        .push_strb  (push_strb),
        .credit     (credit)
    );

    axil_fall_through_buffer #(
        .DEPTH        (DEPTH),
        .FALL_THROUGH (FALL_THROUGH)
    ) axil_fall_through_buffer_i (
        .seq         (seq),
        .rst_n       (rst_n),
        .push        (push),
        .push_write  (push_write),
        .push_addr   (push_addr),
        .push_data   (push_data),
        .push_strb   (push_strb),
        .entry_valid (entry_valid),
        .entry_write (entry_write),
        .entry_addr  (entry_addr),
        .entry_data  (entry_data),
        .entry_strb  (entry_strb),
        .pop         (pop),
        .credit      (credit)
    );

    axil_reg_consumer axil_reg_consumer_i (
        .seq         (seq),
        .rst_n       (rst_n),
        .entry_valid (entry_valid),
        .entry_write (entry_write),
        .entry_addr  (entry_addr),
        .entry_data  (entry_data),
        .entry_strb  (entry_strb),
        .pop         (pop),
        .b_valid     (b_valid),
        .b_ready     (b_ready),
        .b_resp      (b_resp),
        .r_valid     (r_valid),
        .r_ready     (r_ready),
        .r_data      (r_data),
        .r_resp      (r_resp)
    );

endmodule

//--- testbench/axil_ft_props.sv
`timescale 1ns/100ps

module axil_ft_props
    import axil_ft_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input logic  seq,
    input logic  rst_n,
    input logic  push,
    input logic  pop,
    input logic  [$clog2(DEPTH + 1)-1:0] count,
    input logic  b_valid,
    input logic  b_ready,
    input resp_t b_resp,
    input logic  r_valid,
    input logic  r_ready,
    input data_t r_data,
    input resp_t r_resp
);

    int occupancy;
    int failures = 0;

    // a bypassed request adds one and takes one in the same cycle
    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(push) - int'(pop);
        end
    end

    no_push_when_full: assert property (@(posedge seq) disable iff (!rst_n)
        push |-> occupancy < DEPTH)
        else begin
            $error("push arrived while the buffer held %0d entries", occupancy);
            failures++;
        end

    occupancy_bound: assert property (@(posedge seq) disable iff (!rst_n)
        count <= DEPTH)
        else begin
            $error("buffer count %0d is above its depth", count);
            failures++;
        end

    b_held: assert property (@(posedge seq) disable iff (!rst_n)
        b_valid && !b_ready |=> b_valid && $stable(b_resp))
        else begin
            $error("write response dropped or changed before b_ready");
            failures++;
        end

    r_held: assert property (@(posedge seq) disable iff (!rst_n)
        r_valid && !r_ready |=> r_valid && $stable(r_data) && $stable(r_resp))
        else begin
            $error("read response dropped or changed before r_ready");
            failures++;
        end

endmodule

bind axil_ft_top axil_ft_props #(.DEPTH(DEPTH)) axil_ft_props_i (
    .seq     (seq),
    .rst_n   (rst_n),
    .push    (push),
    .pop     (pop),
    .count   (axil_fall_through_buffer_i.count),
    .b_valid (b_valid),
    .b_ready (b_ready),
    .b_resp  (b_resp),
    .r_valid (r_valid),
    .r_ready (r_ready),
    .r_data  (r_data),
    .r_resp  (r_resp)
);

//--- testbench/axil_ft_checker.sv
`timescale 1ns/100ps

module axil_ft_checker
    import axil_ft_pkg::*;
(
    input  logic  seq,
    input  logic  rst_n,
    input  logic  aw_valid,
    input  logic  aw_ready,
    input  addr_t aw_addr,
    input  logic  w_valid,
    input  logic  w_ready,
    input  data_t w_data,
    input  strb_t w_strb,
    input  logic  ar_valid,
    input  logic  ar_ready,
    input  addr_t ar_addr,
    input  logic  b_valid,
    input  logic  b_ready,
    input  resp_t b_resp,
    input  logic  r_valid,
    input  logic  r_ready,
    input  data_t r_data,
    input  resp_t r_resp,
    output int    error_count,
    output int    accept_count,
    output int    response_count
);

    data_t model [REG_COUNT];
    logic  exp_write [$];
    resp_t exp_resp [$];
    data_t exp_data [$];

    // only bits 5:2 may be set
    function automatic logic addr_in_range(input addr_t addr);
        return addr[ADDR_WIDTH-1:6] == '0;
    endfunction

    task automatic check_response(input logic is_write, input resp_t resp, input data_t data);
        if (exp_write.size() == 0) begin
            $display("%s response arrived with no request outstanding",
                     is_write ? "write" : "read");
            error_count++;
        end else begin
            if (exp_write[0] != is_write) begin
                $display("%s response arrived while the oldest request is of the other kind",
                         is_write ? "write" : "read");
                error_count++;
            end else if (resp != exp_resp[0]) begin
                $display("error: %s is %h, expected %h",
                         is_write ? "b_resp" : "r_resp", resp, exp_resp[0]);
                error_count++;
            end
            if (exp_write[0] == is_write && !is_write && data != exp_data[0]) begin
                $display("error: r_data is %h, expected %h", data, exp_data[0]);
                error_count++;
            end
            void'(exp_write.pop_front());
            void'(exp_resp.pop_front());
            void'(exp_data.pop_front());
        end
        response_count++;
    endtask

    // handshakes are settled by the falling edge and transfer on the next rising one
    always @(negedge seq) begin
        if (!rst_n) begin
            foreach (model[i]) begin
                model[i] = '0;
            end
            exp_write.delete();
            exp_resp.delete();
            exp_data.delete();
            error_count    = 0;
            accept_count   = 0;
            response_count = 0;
        end else begin
            if (aw_valid && aw_ready && w_valid && w_ready) begin
                if (addr_in_range(aw_addr)) begin
                    for (int b = 0; b < STRB_WIDTH; b++) begin
                        if (w_strb[b]) begin
                            model[aw_addr[5:2]][8*b +: 8] = w_data[8*b +: 8];
                        end
                    end
                end
                exp_write.push_back(1'b1);
                exp_resp.push_back(addr_in_range(aw_addr) ? RESP_OKAY : RESP_SLVERR);
                exp_data.push_back('0);
                accept_count++;
            end
            if (ar_valid && ar_ready) begin
                exp_write.push_back(1'b0);
                exp_resp.push_back(addr_in_range(ar_addr) ? RESP_OKAY : RESP_SLVERR);
                exp_data.push_back(addr_in_range(ar_addr) ? model[ar_addr[5:2]] : '0);
                accept_count++;
            end
            if (b_valid && b_ready) begin
                check_response(1'b1, b_resp, '0);
            end
            if (r_valid && r_ready) begin
                check_response(1'b0, r_resp, r_data);
            end
        end
    end

endmodule

//--- testbench/axil_ft_tb.sv
`timescale 1ns/100ps

module axil_ft_tb;
    import axil_ft_pkg::*;

    localparam int DEPTH        = 4;
    localparam int FALL_THROUGH = 1;
    localparam int PERIOD       = 40;
    localparam int WAIT_LIMIT   = 200;
    // reset plus about 230 directed, 2000 random and 154 drain cycles
    localparam int STIM_CYCLES  = 16 + 230 + 2000 + 154;

    logic  seq;
    logic  rst_n;
    logic  aw_valid, aw_ready, w_valid, w_ready, ar_valid, ar_ready;
    logic  b_valid, b_ready, r_valid, r_ready;
    addr_t aw_addr, ar_addr;
    data_t w_data, r_data;
    strb_t w_strb;
    resp_t b_resp, r_resp;

    int error_count;
    int accept_count;
    int response_count;
    int tb_errors   = 0;
    int errors_seen = 0;
    int test_num    = 1;

    logic [31:0] lfsr = 32'h473f9421;

    axil_ft_top #(
        .DEPTH        (DEPTH),
        .FALL_THROUGH (FALL_THROUGH)
    ) axil_ft_top_i (.*);

    axil_ft_checker checker_i (.*);

    initial begin
        seq = 1'b0;
        forever #(PERIOD / 2) seq = ~seq;
    end

    initial begin
        #(STIM_CYCLES * PERIOD * 4);
        $display("watchdog expired after %0d ns with the tests unfinished",
                 STIM_CYCLES * PERIOD * 4);
        $display("TEST FAIL");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // random numbers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    function automatic addr_t outside_addr();
        addr_t upper;
        upper = addr_t'((take_bits(26) | 32'h1) << 6);
        return upper | addr_t'(take_bits(4) << 2);
    endfunction

    function automatic addr_t random_addr();
        if (take_bits(4) == 0) begin
            return outside_addr();
        end
        return addr_t'(take_bits(4) << 2);
    endfunction

    function automatic int errors_so_far();
        return error_count + tb_errors + axil_ft_top_i.axil_ft_props_i.failures;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus tasks that start and end 2 ns after a rising edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic send(input logic is_write, input addr_t addr, input data_t data,
                        input strb_t strb);
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        if (is_write) begin
            aw_valid = 1'b1;
            w_valid  = 1'b1;
            aw_addr  = addr;
            w_data   = data;
            w_strb   = strb;
        end else begin
            ar_valid = 1'b1;
            ar_addr  = addr;
        end
        while (!taken && waited < WAIT_LIMIT) begin
            @(negedge seq);
            taken = is_write ? (aw_ready && w_ready) : ar_ready;
            waited++;
        end
        if (!taken) begin
            $display("%s to %h was not accepted within %0d cycles",
                     is_write ? "write" : "read", addr, WAIT_LIMIT);
            tb_errors++;
        end
        @(posedge seq);
        #2;
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        ar_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited  = 0;
        b_ready = 1'b1;
        r_ready = 1'b1;
        while ((response_count != accept_count || b_valid || r_valid)
               && waited < WAIT_LIMIT) begin
            @(posedge seq);
            #2;
            waited++;
        end
        if (response_count != accept_count) begin
            $display("%0d responses still missing after %0d cycles",
                     accept_count - response_count, WAIT_LIMIT);
            tb_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %0d, %s: %0d errors", test_num, name,
                 errors_so_far() - errors_seen);
        errors_seen = errors_so_far();
        test_num++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tests with their own timing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic hold_responses();
        int taken;
        taken   = 0;
        b_ready = 1'b0;
        r_ready = 1'b0;
        for (int c = 0; c < 24; c++) begin
            aw_valid = 1'b1;
            w_valid  = 1'b1;
            // odd ones land outside the bank so SLVERR and OKAY alternate
            aw_addr  = taken[0] ? addr_t'(32'h40 + taken * 4) : addr_t'(taken * 4);
            w_data   = data_t'(32'hd0d0_0000 + taken);
            w_strb   = 4'hf;
            @(negedge seq);
            if (aw_ready) begin
                taken++;
            end
            @(posedge seq);
            #2;
        end
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        if (taken != DEPTH + 1) begin
            $display("%0d writes accepted under back-pressure, expected %0d",
                     taken, DEPTH + 1);
            tb_errors++;
        end
        drain();
    endtask

    task automatic random_traffic(input int cycles);
        int   c;
        logic wr_done;
        logic rd_done;
        c = 0;
        while (c < cycles || aw_valid || ar_valid) begin
            if (c < cycles) begin
                b_ready = (take_bits(2) != 0);
                r_ready = (take_bits(2) != 0);
                if (!aw_valid && take_bits(2) == 0) begin
                    aw_valid = 1'b1;
                    w_valid  = 1'b1;
                    aw_addr  = random_addr();
                    w_data   = take_bits(32);
                    w_strb   = strb_t'(take_bits(4));
                end
                if (!ar_valid && take_bits(3) == 0) begin
                    ar_valid = 1'b1;
                    ar_addr  = random_addr();
                end
            end else begin
                b_ready = 1'b1;
                r_ready = 1'b1;
            end
            @(negedge seq);
            wr_done = aw_valid && aw_ready;
            rd_done = ar_valid && ar_ready;
            @(posedge seq);
            #2;
            if (wr_done) begin
                aw_valid = 1'b0;
                w_valid  = 1'b0;
            end
            if (rd_done) begin
                ar_valid = 1'b0;
            end
            c++;
        end
        drain();
    endtask

    task automatic check_latency(input logic is_write, input addr_t addr);
        logic taken;
        logic early;
        logic resp_valid;
        drain();
        if (is_write) begin
            aw_valid = 1'b1;
            w_valid  = 1'b1;
            aw_addr  = addr;
            w_data   = take_bits(32);
            w_strb   = 4'hf;
        end else begin
            ar_valid = 1'b1;
            ar_addr  = addr;
        end
        @(negedge seq);
        taken = is_write ? aw_ready : ar_ready;
        early = b_valid || r_valid;
        @(posedge seq);
        #2;
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        ar_valid = 1'b0;
        @(negedge seq);
        resp_valid = is_write ? b_valid : r_valid;
        if (!taken) begin
            $display("%s on an idle endpoint was not accepted at once",
                     is_write ? "write" : "read");
            tb_errors++;
        end else if (early) begin
            $display("a response was already valid when the request was accepted");
            tb_errors++;
        end else if (!resp_valid) begin
            $display("error: %s is %h one cycle after acceptance, expected %h",
                     is_write ? "b_valid" : "r_valid", resp_valid, 1'b1);
            tb_errors++;
        end
        @(posedge seq);
        #2;
        drain();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int total_errors;
        aw_valid = 1'b0;
        aw_addr  = '0;
        w_valid  = 1'b0;
        w_data   = '0;
        w_strb   = '0;
        ar_valid = 1'b0;
        ar_addr  = '0;
        b_ready  = 1'b0;
        r_ready  = 1'b0;
        rst_n    = 1'b0;
        repeat (16) @(posedge seq);
        #2;
        rst_n = 1'b1;

        b_ready = 1'b1;
        r_ready = 1'b1;
        for (int i = 0; i < REG_COUNT; i++) begin
            send(1'b1, addr_t'(i * 4), take_bits(32), 4'hf);
        end
        for (int i = 0; i < REG_COUNT; i++) begin
            send(1'b0, addr_t'(i * 4), '0, '0);
        end
        drain();
        finish_test("full-strobe writes read back");

        for (int i = 0; i < 24; i++) begin
            send(1'b1, addr_t'(take_bits(4) << 2), take_bits(32), strb_t'(take_bits(4)));
        end
        for (int i = 0; i < REG_COUNT; i++) begin
            send(1'b0, addr_t'(i * 4), '0, '0);
        end
        drain();
        finish_test("partial strobes");

        // out-of-range writes change nothing and reads there give zero
        for (int i = 0; i < 6; i++) begin
            send(1'b1, outside_addr(), take_bits(32), 4'hf);
        end
        for (int i = 0; i < REG_COUNT; i++) begin
            send(1'b0, addr_t'(i * 4), '0, '0);
        end
        for (int i = 0; i < 4; i++) begin
            send(1'b0, outside_addr(), '0, '0);
        end
        drain();
        finish_test("out-of-range addresses");

        hold_responses();
        finish_test("back-pressure fills the buffer");

        random_traffic(2000);
        finish_test("random traffic");

        check_latency(1'b1, 32'h8);
        check_latency(1'b0, 32'h8);
        finish_test("idle latency");

        total_errors = errors_so_far();
        $display("%0d tests, %0d requests accepted, %0d responses, %0d errors",
                 test_num - 1, accept_count, response_count, total_errors);
        if (total_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
logic/axil_ft_pkg.sv
logic/axil_req_producer.sv
logic/axil_fall_through_buffer.sv
logic/axil_reg_consumer.sv
logic/axil_ft_top.sv
testbench/axil_ft_props.sv
testbench/axil_ft_checker.sv
testbench/axil_ft_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module axil_ft_tb -f files.f -Mdir obj_dir

./obj_dir/Vaxil_ft_tb | tee sim.log

if grep -qx "TEST PASS" sim.log; then
    exit 0
fi
exit 1
